// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exe_stage
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "simulation ended without result"; exit 1)
	@echo "simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
+incdir+.
mips_pkg.sv
exe_ctrl_if.sv
exe_alu.sv
exe_decoder.sv
exe_muldiv.sv
exe_stage.sv
tb_exe_stage.sv

// File: exe_alu.sv
`timescale 1ns/1ns

module exe_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_e op,
    output logic [31:0]       res,
    output logic              overflow
);

    logic [32:0] sum_ext;
    logic [32:0] dif_ext;

    // sign bit doubled, the two top bits differ on signed overflow
    assign sum_ext = {a[31], a} + {b[31], b};
    assign dif_ext = {a[31], a} - {b[31], b};

    always_comb begin
        overflow = 1'b0;
        case (op)
            mips_pkg::alu_add: begin
                res      = sum_ext[31:0];
                overflow = sum_ext[32] != sum_ext[31];
            end
            mips_pkg::alu_sub: begin
                res      = dif_ext[31:0];
                overflow = dif_ext[32] != dif_ext[31];
            end
            mips_pkg::alu_addu:   res = a + b;
            mips_pkg::alu_subu:   res = a - b;
            mips_pkg::alu_and:    res = a & b;
            mips_pkg::alu_or:     res = a | b;
            mips_pkg::alu_xor:    res = a ^ b;
            mips_pkg::alu_nor:    res = ~(a | b);
            mips_pkg::alu_slt:    res = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::alu_sltu:   res = {31'b0, a < b};
            mips_pkg::alu_sll:    res = b << a[4:0]; // shift amount rides on a
            mips_pkg::alu_srl:    res = b >> a[4:0];
            mips_pkg::alu_sra:    res = $signed(b) >>> a[4:0];
            mips_pkg::alu_pass_b: res = b;
            default:              res = 32'b0;
        endcase
    end

endmodule

// File: exe_ctrl_if.sv
`timescale 1ns/1ns

interface exe_ctrl_if;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::mdu_op_e   mdu_op;
    mips_pkg::src_a_e    src_a;
    mips_pkg::src_b_e    src_b;
    mips_pkg::wb_src_e   wb_src;
    mips_pkg::wb_dst_e   wb_dst;
    mips_pkg::hilo_out_e hilo_out;
    logic                ov_ari;    // trap on signed overflow
    logic                is_load;
    logic                is_store;
    logic                mdu_start; // any op that touches hi/lo

    modport dec (
        output alu_op, mdu_op, src_a, src_b, wb_src, wb_dst, hilo_out,
        output ov_ari, is_load, is_store, mdu_start
    );

    modport dp (
        input alu_op, mdu_op, src_a, src_b, wb_src, wb_dst, hilo_out,
        input ov_ari, is_load, is_store, mdu_start
    );

endinterface

// File: exe_decoder.sv
`timescale 1ns/1ns

module exe_decoder (
    input  mips_pkg::instr_u instr,
    output logic [4:0]       t_new,
    exe_ctrl_if.dec          ctrl
);

    logic valid;

    always_comb begin
        ctrl.alu_op    = mips_pkg::alu_addu;
        ctrl.mdu_op    = mips_pkg::mdu_none;
        ctrl.src_a     = mips_pkg::src_a_rs;
        ctrl.src_b     = mips_pkg::src_b_rt;
        ctrl.wb_src    = mips_pkg::wb_none;
        ctrl.wb_dst    = mips_pkg::dst_none;
        ctrl.hilo_out  = mips_pkg::hilo_none;
        ctrl.ov_ari    = 1'b0;
        ctrl.is_load   = 1'b0;
        ctrl.is_store  = 1'b0;
        ctrl.mdu_start = 1'b0;

        case (instr.i_fmt.opcode)
            mips_pkg::op_special: begin
                ctrl.wb_dst = mips_pkg::dst_rd;
                case (instr.r_fmt.funct)
                    mips_pkg::fn_add: begin
                        ctrl.alu_op = mips_pkg::alu_add;
                        ctrl.ov_ari = 1'b1;
                    end
                    mips_pkg::fn_sub: begin
                        ctrl.alu_op = mips_pkg::alu_sub;
                        ctrl.ov_ari = 1'b1;
                    end
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_addu;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_subu;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:  ctrl.alu_op = mips_pkg::alu_nor;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
                    // amount on a, value on b
                    mips_pkg::fn_sllv: ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srlv: ctrl.alu_op = mips_pkg::alu_srl;
                    mips_pkg::fn_srav: ctrl.alu_op = mips_pkg::alu_sra;
                    mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra: begin
                        ctrl.src_a  = mips_pkg::src_a_shamt;
                        ctrl.alu_op = (instr.r_fmt.funct == mips_pkg::fn_sll) ? mips_pkg::alu_sll :
                                      (instr.r_fmt.funct == mips_pkg::fn_srl) ? mips_pkg::alu_srl :
                                                                               mips_pkg::alu_sra;
                    end
                    mips_pkg::fn_mfhi: ctrl.hilo_out = mips_pkg::hilo_hi;
                    mips_pkg::fn_mflo: ctrl.hilo_out = mips_pkg::hilo_lo;
                    mips_pkg::fn_mthi, mips_pkg::fn_mtlo: begin
                        ctrl.wb_dst    = mips_pkg::dst_none;
                        ctrl.src_b     = mips_pkg::src_b_rs; // alu_res shows the moved value
                        ctrl.alu_op    = mips_pkg::alu_pass_b;
                        ctrl.mdu_start = 1'b1;
                        ctrl.mdu_op    = (instr.r_fmt.funct == mips_pkg::fn_mthi) ?
                                         mips_pkg::mdu_mthi : mips_pkg::mdu_mtlo;
                    end
                    mips_pkg::fn_mult, mips_pkg::fn_multu,
                    mips_pkg::fn_div, mips_pkg::fn_divu: begin
                        ctrl.wb_dst    = mips_pkg::dst_none;
                        ctrl.mdu_start = 1'b1;
                        case (instr.r_fmt.funct)
                            mips_pkg::fn_mult:  ctrl.mdu_op = mips_pkg::mdu_mult;
                            mips_pkg::fn_multu: ctrl.mdu_op = mips_pkg::mdu_multu;
                            mips_pkg::fn_div:   ctrl.mdu_op = mips_pkg::mdu_div;
                            default:            ctrl.mdu_op = mips_pkg::mdu_divu;
                        endcase
                    end
                    default: ctrl.wb_dst = mips_pkg::dst_none;
                endcase
            end
            mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
            mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui: begin
                ctrl.src_b  = mips_pkg::src_b_imm;
                ctrl.wb_dst = mips_pkg::dst_rt;
                case (instr.i_fmt.opcode)
                    mips_pkg::op_addi: begin
                        ctrl.alu_op = mips_pkg::alu_add;
                        ctrl.ov_ari = 1'b1;
                    end
                    mips_pkg::op_slti: ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::op_sltiu: ctrl.alu_op = mips_pkg::alu_sltu;
                    mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::op_xori: ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::op_lui: begin
                        ctrl.alu_op = mips_pkg::alu_pass_b;
                        ctrl.wb_src = mips_pkg::wb_imm; // imm32 already shifted upstream
                    end
                    default: ctrl.alu_op = mips_pkg::alu_addu;
                endcase
            end
            mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw,
            mips_pkg::op_lbu, mips_pkg::op_lhu: begin
                ctrl.alu_op  = mips_pkg::alu_add; // address overflow -> adel
                ctrl.src_b   = mips_pkg::src_b_imm;
                ctrl.wb_dst  = mips_pkg::dst_rt;
                ctrl.is_load = 1'b1;
            end
            mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw: begin
                ctrl.alu_op   = mips_pkg::alu_add;
                ctrl.src_b    = mips_pkg::src_b_imm;
                ctrl.is_store = 1'b1;
            end
            mips_pkg::op_jal: begin
                ctrl.wb_src = mips_pkg::wb_pc8;
                ctrl.wb_dst = mips_pkg::dst_ra;
            end
            default: ;
        endcase

        // cycles until the value exists
        if (ctrl.wb_dst == mips_pkg::dst_none || ctrl.wb_src != mips_pkg::wb_none)
            t_new = 5'd0;
        else if (ctrl.is_load)
            t_new = 5'd2;
        else
            t_new = 5'd1;

        // supported opcode and funct set
        valid = (instr.i_fmt.opcode == mips_pkg::op_special) ?
                (instr.r_fmt.funct inside {
                    mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra,
                    mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav,
                    mips_pkg::fn_mfhi, mips_pkg::fn_mthi, mips_pkg::fn_mflo, mips_pkg::fn_mtlo,
                    mips_pkg::fn_mult, mips_pkg::fn_multu, mips_pkg::fn_div, mips_pkg::fn_divu,
                    mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub, mips_pkg::fn_subu,
                    mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
                    mips_pkg::fn_slt, mips_pkg::fn_sltu}) :
                (instr.i_fmt.opcode inside {
                    mips_pkg::op_jal, mips_pkg::op_addi, mips_pkg::op_addiu,
                    mips_pkg::op_slti, mips_pkg::op_sltiu, mips_pkg::op_andi,
                    mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui,
                    mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw, mips_pkg::op_lbu,
                    mips_pkg::op_lhu, mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw});

        // an unknown word must not write a register or disturb hi/lo
        assert (valid || (ctrl.wb_dst == mips_pkg::dst_none && !ctrl.mdu_start));
    end

endmodule

// File: exe_muldiv.sv
`timescale 1ns/1ns

module exe_muldiv #(
    parameter int MUL_CYCLES = 5,
    parameter int DIV_CYCLES = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       d1,
    input  logic [31:0]       d2,
    input  mips_pkg::mdu_op_e op,
    input  logic              start,
    output logic [31:0]       hi,
    output logic [31:0]       lo,
    output logic              busy
);

    localparam int MAX_CYCLES = (MUL_CYCLES > DIV_CYCLES) ? MUL_CYCLES : DIV_CYCLES;
    localparam int CW = $clog2(MAX_CYCLES + 1);

    logic [CW-1:0]     cnt;
    mips_pkg::mdu_op_e op_q;
    logic [31:0]       a_q;
    logic [31:0]       b_q;

    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;
    logic [31:0]        quo_s, rem_s;
    logic [31:0]        quo_u, rem_u;

    assign busy = cnt != '0;

    assign prod_s = $signed(a_q) * $signed(b_q);
    assign prod_u = {32'b0, a_q} * {32'b0, b_q};
    assign quo_s  = $signed(a_q) / $signed(b_q);
    assign rem_s  = $signed(a_q) % $signed(b_q);
    assign quo_u  = a_q / b_q;
    assign rem_u  = a_q % b_q;

    // latched operands, only read while counting
    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= op;
            a_q  <= d1;
            b_q  <= d2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            hi  <= 32'b0;
            lo  <= 32'b0;
        end else if (start) begin
            case (op)
                mips_pkg::mdu_mthi: hi <= d1;
                mips_pkg::mdu_mtlo: lo <= d1;
                mips_pkg::mdu_mult, mips_pkg::mdu_multu: cnt <= CW'(MUL_CYCLES);
                mips_pkg::mdu_div, mips_pkg::mdu_divu:   cnt <= CW'(DIV_CYCLES);
                default: cnt <= '0;
            endcase
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CW'(1)) begin // last busy cycle, commit
                case (op_q)
                    mips_pkg::mdu_mult: begin
                        hi <= prod_s[63:32];
                        lo <= prod_s[31:0];
                    end
                    mips_pkg::mdu_multu: begin
                        hi <= prod_u[63:32];
                        lo <= prod_u[31:0];
                    end
                    mips_pkg::mdu_div: begin
                        if (b_q != 32'b0) begin // div by zero keeps hi/lo
                            hi <= rem_s;
                            lo <= quo_s;
                        end
                    end
                    mips_pkg::mdu_divu: begin
                        if (b_q != 32'b0) begin
                            hi <= rem_u;
                            lo <= quo_u;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // stage gating must hold off a new op until the unit is free
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

    a_busy_bound: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:DIV_CYCLES] !busy);

endmodule

// File: exe_stage.sv
`timescale 1ns/1ns

module exe_stage #(
    parameter int MUL_CYCLES = 5,
    parameter int DIV_CYCLES = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pause,
    input  logic [31:0] imm32,
    input  logic [31:0] reg_rs,
    input  logic [31:0] reg_rt,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] alu_res,
    output logic [31:0] mlu_res,
    output logic [31:0] reg_write,
    output logic [4:0]  regw_adr,
    output logic [4:0]  t_new,
    output logic [4:0]  exc_code,
    output logic        busy
);

    mips_pkg::instr_u ins;
    logic [31:0]      op_a, op_b;
    logic [31:0]      hi, lo;
    logic             alu_ovf;
    logic             busy_core;
    logic             md_req;   // instruction needs the hi/lo unit
    logic             md_done;  // current md instruction already accepted
    logic             md_go;
    logic             mdu_start;

    exe_ctrl_if ctrl ();

    assign ins = instr;

    always_comb begin
        case (ctrl.src_a)
            mips_pkg::src_a_rs:    op_a = reg_rs;
            mips_pkg::src_a_shamt: op_a = {27'b0, ins.r_fmt.shamt};
            default:               op_a = 32'b0;
        endcase
        case (ctrl.src_b)
            mips_pkg::src_b_rt:  op_b = reg_rt;
            mips_pkg::src_b_imm: op_b = imm32;
            mips_pkg::src_b_rs:  op_b = reg_rs;
            default:             op_b = 32'b0;
        endcase
    end

    always_comb begin
        case (ctrl.wb_src)
            mips_pkg::wb_imm: reg_write = imm32;
            mips_pkg::wb_pc8: reg_write = pc + 32'd8; // link past the delay slot
            default:          reg_write = 32'b0;
        endcase
        case (ctrl.wb_dst)
            mips_pkg::dst_rt: regw_adr = ins.r_fmt.rt;
            mips_pkg::dst_rd: regw_adr = ins.r_fmt.rd;
            mips_pkg::dst_ra: regw_adr = 5'd31;
            default:          regw_adr = 5'd0;
        endcase
        case (ctrl.hilo_out)
            mips_pkg::hilo_hi: mlu_res = hi;
            mips_pkg::hilo_lo: mlu_res = lo;
            default:           mlu_res = 32'b0;
        endcase
    end

    always_comb begin
        if (ctrl.ov_ari && alu_ovf)
            exc_code = mips_pkg::exc_ov_ari;
        else if (ctrl.is_store && alu_ovf)
            exc_code = mips_pkg::exc_ad_s;
        else if (ctrl.is_load && alu_ovf)
            exc_code = mips_pkg::exc_ad_l;
        else
            exc_code = 5'd0;
    end

    assign md_req    = ctrl.mdu_start || (ctrl.hilo_out != mips_pkg::hilo_none);
    assign md_go     = md_req && !md_done && !busy_core && !pause;
    assign mdu_start = ctrl.mdu_start && md_go;
    assign busy      = busy_core || (md_req && !md_done);

    // cleared once the stage lets the instruction go
    always_ff @(posedge clk) begin
        if (rst)
            md_done <= 1'b0;
        else if (!busy && !pause)
            md_done <= 1'b0;
        else if (md_go)
            md_done <= 1'b1;
    end

    exe_decoder dec_i (
        .instr (ins),
        .t_new (t_new),
        .ctrl  (ctrl)
    );

    exe_alu alu_i (
        .a        (op_a),
        .b        (op_b),
        .op       (ctrl.alu_op),
        .res      (alu_res),
        .overflow (alu_ovf)
    );

    exe_muldiv #(
        .MUL_CYCLES (MUL_CYCLES),
        .DIV_CYCLES (DIV_CYCLES)
    ) mdu_i (
        .clk   (clk),
        .rst   (rst),
        .d1    (op_a),
        .d2    (op_b),
        .op    (ctrl.mdu_op),
        .start (mdu_start),
        .hi    (hi),
        .lo    (lo),
        .busy  (busy_core)
    );

endmodule

// File: mips_pkg.sv
package mips_pkg;

    // two views of the same instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        mdu_none, mdu_mult, mdu_multu, mdu_div, mdu_divu, mdu_mthi, mdu_mtlo
    } mdu_op_e;

    typedef enum logic [1:0] {src_a_rs, src_a_shamt} src_a_e;
    typedef enum logic [1:0] {src_b_rt, src_b_imm, src_b_rs} src_b_e;
    typedef enum logic [1:0] {wb_none, wb_imm, wb_pc8} wb_src_e;
    typedef enum logic [1:0] {dst_none, dst_rt, dst_rd, dst_ra} wb_dst_e;
    typedef enum logic [1:0] {hilo_none, hilo_hi, hilo_lo} hilo_out_e;

    localparam logic [4:0] exc_ov_ari = 5'd12;
    localparam logic [4:0] exc_ad_l   = 5'd4;
    localparam logic [4:0] exc_ad_s   = 5'd5;

    // opcodes
    localparam logic [5:0] op_special = 6'h00, op_jal   = 6'h03;
    localparam logic [5:0] op_addi    = 6'h08, op_addiu = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a, op_sltiu = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c, op_ori   = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e, op_lui   = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20, op_lh    = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23, op_lbu   = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25, op_sb    = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29, op_sw    = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00, fn_srl   = 6'h02, fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04, fn_srlv  = 6'h06, fn_srav = 6'h07;
    localparam logic [5:0] fn_mfhi = 6'h10, fn_mthi  = 6'h11;
    localparam logic [5:0] fn_mflo = 6'h12, fn_mtlo  = 6'h13;
    localparam logic [5:0] fn_mult = 6'h18, fn_multu = 6'h19;
    localparam logic [5:0] fn_div  = 6'h1a, fn_divu  = 6'h1b;
    localparam logic [5:0] fn_add  = 6'h20, fn_addu  = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22, fn_subu  = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24, fn_or    = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26, fn_nor   = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a, fn_sltu  = 6'h2b;

endpackage

// File: tb_exe_model.svh
logic [31:0] lfsr_state = 32'h4b52;
logic [31:0] model_hi = 32'b0;
logic [31:0] model_lo = 32'b0;

// expected response of the instruction in flight
logic [31:0] exp_alu, exp_wb, exp_mlu;
logic [4:0]  exp_adr, exp_tnew, exp_exc;
logic        exp_busy, chk_alu, chk_mlu;
int          exp_hold; // busy cycles after the issue cycle

localparam logic [5:0] fn_pool [0:23] = '{
    mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub, mips_pkg::fn_subu,
    mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
    mips_pkg::fn_slt, mips_pkg::fn_sltu, mips_pkg::fn_sll, mips_pkg::fn_srl,
    mips_pkg::fn_sra, mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav,
    mips_pkg::fn_mult, mips_pkg::fn_multu, mips_pkg::fn_div, mips_pkg::fn_divu,
    mips_pkg::fn_mthi, mips_pkg::fn_mtlo, mips_pkg::fn_mfhi, mips_pkg::fn_mflo
};
localparam logic [5:0] op_pool [0:16] = '{
    mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
    mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui,
    mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw, mips_pkg::op_lbu,
    mips_pkg::op_lhu, mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw, mips_pkg::op_jal
};

// galois lfsr, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int i;
    r = 32'b0;
    for (i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
endfunction

// same operand signs for add, opposite for sub, then result sign flipped
function automatic logic signed_ovf(input logic [31:0] a, input logic [31:0] b,
                                    input logic [31:0] s, input logic is_sub);
    return ((a[31] ^ b[31]) == is_sub) && (s[31] != a[31]);
endfunction

task automatic gen_instr(output logic [31:0] ins, output logic [31:0] rs_v,
                         output logic [31:0] rt_v, output logic [31:0] imm_v,
                         output logic [31:0] pc_v);
    int k;
    logic [5:0] opc;
    logic [5:0] fn;
    logic [31:0] r;
    k = int'(rand_bits(6) % 32'd41);
    r = rand_bits(6);
    opc = (k < 24) ? mips_pkg::op_special : op_pool[k - 24];
    fn = (k < 24) ? fn_pool[k] : r[5:0];
    r = rand_bits(20);
    ins = {opc, r[19:0], fn};
    rs_v = rand_bits(32);
    rt_v = rand_bits(32);
    r = rand_bits(30);
    pc_v = {r[29:0], 2'b00};
    if (rand_bits(2) == 32'd0) begin // push operands across the signed limit
        r = rand_bits(16);
        if (opc == mips_pkg::op_special && fn inside {mips_pkg::fn_add, mips_pkg::fn_addu}) begin
            rs_v = {1'b0, 15'h7fff, r[15:0]};
            rt_v = {1'b0, 15'h7fff, r[7:0], r[15:8]};
        end else if (opc == mips_pkg::op_special &&
                     fn inside {mips_pkg::fn_sub, mips_pkg::fn_subu}) begin
            rs_v = {1'b1, 15'b0, r[15:0]};
            rt_v = {1'b0, 15'h7fff, r[7:0], r[15:8]};
        end else if (opc != mips_pkg::op_special) begin
            rs_v = {1'b0, 17'h1ffff, r[13:0]};
            ins[15:14] = 2'b01; // large positive offset
        end
    end
    if (opc == mips_pkg::op_special && fn inside {mips_pkg::fn_div, mips_pkg::fn_divu} &&
        rand_bits(3) == 32'd0)
        rt_v = 32'b0;
    case (opc)
        mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: imm_v = {16'b0, ins[15:0]};
        mips_pkg::op_lui: imm_v = {ins[15:0], 16'b0};
        default:          imm_v = {{16{ins[15]}}, ins[15:0]};
    endcase
endtask

task automatic predict(input logic [31:0] ins, input logic [31:0] rs_v,
                       input logic [31:0] rt_v, input logic [31:0] imm_v,
                       input logic [31:0] pc_v);
    logic [5:0] opc;
    logic [5:0] fn;
    logic [4:0] sh;
    logic       ov;
    opc = ins[31:26];
    fn = ins[5:0];
    sh = ins[10:6];
    exp_alu = 32'b0;
    exp_wb = 32'b0;
    exp_mlu = 32'b0;
    exp_adr = 5'd0;
    exp_tnew = 5'd0;
    exp_exc = 5'd0;
    exp_busy = 1'b0;
    exp_hold = 0;
    chk_alu = 1'b1;
    chk_mlu = 1'b0;
    if (opc == mips_pkg::op_special) begin
        exp_adr = ins[15:11];
        exp_tnew = 5'd1;
        case (fn)
            mips_pkg::fn_add, mips_pkg::fn_addu: begin
                exp_alu = rs_v + rt_v;
                if (fn == mips_pkg::fn_add && signed_ovf(rs_v, rt_v, exp_alu, 1'b0))
                    exp_exc = 5'd12;
            end
            mips_pkg::fn_sub, mips_pkg::fn_subu: begin
                exp_alu = rs_v - rt_v;
                if (fn == mips_pkg::fn_sub && signed_ovf(rs_v, rt_v, exp_alu, 1'b1))
                    exp_exc = 5'd12;
            end
            mips_pkg::fn_and:  exp_alu = rs_v & rt_v;
            mips_pkg::fn_or:   exp_alu = rs_v | rt_v;
            mips_pkg::fn_xor:  exp_alu = rs_v ^ rt_v;
            mips_pkg::fn_nor:  exp_alu = ~(rs_v | rt_v);
            mips_pkg::fn_slt:  exp_alu = {31'b0, $signed(rs_v) < $signed(rt_v)};
            mips_pkg::fn_sltu: exp_alu = {31'b0, rs_v < rt_v};
            mips_pkg::fn_sll:  exp_alu = rt_v << sh;
            mips_pkg::fn_srl:  exp_alu = rt_v >> sh;
            mips_pkg::fn_sra:  exp_alu = $signed(rt_v) >>> sh;
            mips_pkg::fn_sllv: exp_alu = rt_v << rs_v[4:0];
            mips_pkg::fn_srlv: exp_alu = rt_v >> rs_v[4:0];
            mips_pkg::fn_srav: exp_alu = $signed(rt_v) >>> rs_v[4:0];
            mips_pkg::fn_mfhi, mips_pkg::fn_mflo: begin
                chk_alu = 1'b0;
                chk_mlu = 1'b1;
                exp_busy = 1'b1;
                exp_mlu = (fn == mips_pkg::fn_mfhi) ? model_hi : model_lo;
            end
            default: begin // mult, div and moves into hi/lo
                chk_alu = 1'b0;
                exp_busy = 1'b1;
                exp_adr = 5'd0;
                exp_tnew = 5'd0;
                if (fn inside {mips_pkg::fn_mult, mips_pkg::fn_multu})
                    exp_hold = mul_cycles;
                else if (fn inside {mips_pkg::fn_div, mips_pkg::fn_divu})
                    exp_hold = div_cycles;
            end
        endcase
    end else if (opc == mips_pkg::op_jal) begin
        chk_alu = 1'b0;
        exp_wb = pc_v + 32'd8;
        exp_adr = 5'd31;
    end else begin
        exp_adr = ins[20:16];
        exp_tnew = 5'd1;
        case (opc)
            mips_pkg::op_slti:  exp_alu = {31'b0, $signed(rs_v) < $signed(imm_v)};
            mips_pkg::op_sltiu: exp_alu = {31'b0, rs_v < imm_v};
            mips_pkg::op_andi:  exp_alu = rs_v & imm_v;
            mips_pkg::op_ori:   exp_alu = rs_v | imm_v;
            mips_pkg::op_xori:  exp_alu = rs_v ^ imm_v;
            mips_pkg::op_lui: begin
                chk_alu = 1'b0;
                exp_wb = imm_v;
                exp_tnew = 5'd0;
            end
            default: begin // addi, addiu and address generation
                exp_alu = rs_v + imm_v;
                ov = signed_ovf(rs_v, imm_v, exp_alu, 1'b0);
                if (opc inside {mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw}) begin
                    exp_adr = 5'd0;
                    exp_tnew = 5'd0;
                    exp_exc = ov ? 5'd5 : 5'd0;
                end else if (opc == mips_pkg::op_addi || opc == mips_pkg::op_addiu) begin
                    exp_exc = (ov && opc == mips_pkg::op_addi) ? 5'd12 : 5'd0;
                end else begin
                    exp_tnew = 5'd2;
                    exp_exc = ov ? 5'd4 : 5'd0;
                end
            end
        endcase
    end
endtask

// hi/lo after the unit finishes
task automatic retire_md(input logic [31:0] ins, input logic [31:0] rs_v,
                         input logic [31:0] rt_v);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] q;
    logic signed [63:0] rm;
    sa = {{32{rs_v[31]}}, rs_v};
    sb = {{32{rt_v[31]}}, rt_v};
    case (ins[5:0])
        mips_pkg::fn_mult:  {model_hi, model_lo} = sa * sb;
        mips_pkg::fn_multu: {model_hi, model_lo} = {32'b0, rs_v} * {32'b0, rt_v};
        mips_pkg::fn_div: begin
            if (rt_v != 32'b0) begin
                q = sa / sb;
                rm = sa % sb;
                model_lo = q[31:0];
                model_hi = rm[31:0];
            end
        end
        mips_pkg::fn_divu: begin
            if (rt_v != 32'b0) begin
                model_lo = rs_v / rt_v;
                model_hi = rs_v % rt_v;
            end
        end
        mips_pkg::fn_mthi: model_hi = rs_v;
        mips_pkg::fn_mtlo: model_lo = rs_v;
        default: ;
    endcase
endtask

// File: tb_exe_stage.sv
`timescale 1ns/1ns

module tb_exe_stage;

    localparam int mul_cycles = 5;
    localparam int div_cycles = 10;
    localparam int n_instr = 400;
    localparam int reset_cycles = 10;
    localparam int max_cycles = n_instr * (div_cycles + 2) + reset_cycles;

    logic        clk;
    logic        rst;
    logic        pause;
    logic [31:0] imm32, reg_rs, reg_rt, pc, instr;
    logic [31:0] alu_res, mlu_res, reg_write;
    logic [4:0]  regw_adr, t_new, exc_code;
    logic        busy;

    int          cycles = 0;
    logic [31:0] ins, rs_v, rt_v, imm_v, pc_v, r;
    logic        paused;
    logic        md_op;
    int          pending;
    int          n;
    int          n_hold;

    `include "tb_exe_model.svh"

    exe_stage #(
        .MUL_CYCLES (mul_cycles),
        .DIV_CYCLES (div_cycles)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .pause     (pause),
        .imm32     (imm32),
        .reg_rs    (reg_rs),
        .reg_rt    (reg_rt),
        .pc        (pc),
        .instr     (instr),
        .alu_res   (alu_res),
        .mlu_res   (mlu_res),
        .reg_write (reg_write),
        .regw_adr  (regw_adr),
        .t_new     (t_new),
        .exc_code  (exc_code),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", max_cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        assert (got == want) else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        rst = 1'b1;
        pause = 1'b0;
        imm32 = 32'b0;
        reg_rs = 32'b0;
        reg_rt = 32'b0;
        pc = 32'b0;
        instr = 32'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("busy", {31'b0, busy}, 32'd0);

        pending = 0;
        for (n = 0; n < n_instr; n++) begin
            gen_instr(ins, rs_v, rt_v, imm_v, pc_v);
            paused = 1'b0;
            if (pending > 0) begin
                // read hi then lo back after every hi/lo op
                ins[31:26] = mips_pkg::op_special;
                ins[5:0] = (pending == 2) ? mips_pkg::fn_mfhi : mips_pkg::fn_mflo;
                pending--;
            end
            md_op = ins[31:26] == mips_pkg::op_special &&
                    ins[5:0] inside {mips_pkg::fn_mult, mips_pkg::fn_multu, mips_pkg::fn_div,
                                     mips_pkg::fn_divu, mips_pkg::fn_mthi, mips_pkg::fn_mtlo};
            if (md_op) begin
                pending = 2;
                r = rand_bits(2);
                paused = ins[5:0] == mips_pkg::fn_mult && r[1:0] == 2'b00;
            end

            @(posedge clk);
            instr <= ins;
            reg_rs <= rs_v;
            reg_rt <= rt_v;
            imm32 <= imm_v;
            pc <= pc_v;
            pause <= paused;
            predict(ins, rs_v, rt_v, imm_v, pc_v);

            @(negedge clk);
            if (chk_alu)
                check_val("alu_res", alu_res, exp_alu);
            if (chk_mlu)
                check_val("mlu_res", mlu_res, exp_mlu);
            check_val("reg_write", reg_write, exp_wb);
            check_val("regw_adr", {27'b0, regw_adr}, {27'b0, exp_adr});
            check_val("t_new", {27'b0, t_new}, {27'b0, exp_tnew});
            check_val("exc_code", {27'b0, exc_code}, {27'b0, exp_exc});
            check_val("busy", {31'b0, busy}, {31'b0, exp_busy});

            if (paused) begin
                // frozen stage, the mult must keep waiting
                repeat (2) begin
                    @(negedge clk);
                    check_val("busy", {31'b0, busy}, 32'd1);
                end
            end else if (exp_busy) begin
                n_hold = 0;
                @(negedge clk);
                while (busy) begin
                    n_hold++;
                    @(negedge clk);
                end
                check_val("busy_len", n_hold, exp_hold);
                if (md_op)
                    retire_md(ins, rs_v, rt_v);
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule
